// File: compile.f
common/mac_arith_pkg.sv
common/mac_ctrl_pkg.sv
approx_multiplier/approx_multiplier.sv
hdl/product_stage.sv
hdl/accumulator.sv
hdl/error_tracker.sv
hdl/mac_control.sv
hdl/approx_mac_top.sv
verification/tb_clock.sv
verification/approx_mac_properties.sv
verification/approx_mac_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.

cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module approx_mac_tb -f compile.f -o approx_mac_sim &&
./obj_dir/approx_mac_sim | tee sim.log &&
grep -q "^TEST PASSED$" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: verification/approx_mac_tb.sv
`timescale 1ns/100ps

module approx_mac_tb import mac_arith_pkg::*, mac_ctrl_pkg::*; ();

    localparam int ACC_WIDTH    = 40;
    localparam int COUNT_WIDTH  = 16;
    localparam int CLK_PERIOD   = 100;
    localparam int LATENCY      = 2;
    localparam int DONE_TIMEOUT = 10;
    localparam int NUM_COMMANDS = 4 + 4 + 4 + 43 + 8 + 11; // Idle NOP slots included.
    localparam int WATCHDOG_NS  = (NUM_COMMANDS + 20) * CLK_PERIOD;

    logic                        clk;
    logic                        reset;
    logic                        cmd_valid;
    mac_opcode_e                 cmd_op;
    operand_t                    x;
    operand_t                    y;
    logic                        done;
    logic signed [ACC_WIDTH-1:0] acc_value;
    logic [ACC_WIDTH-1:0]        err_total;
    logic [COUNT_WIDTH-1:0]      term_count;

    logic signed [ACC_WIDTH-1:0] model_acc;
    logic [ACC_WIDTH-1:0]        model_err;
    logic [COUNT_WIDTH-1:0]      model_count;
    logic signed [ACC_WIDTH-1:0] last_acc;
    logic [ACC_WIDTH-1:0]        exp_acc_q[$];
    logic [ACC_WIDTH-1:0]        exp_err_q[$];
    logic [COUNT_WIDTH-1:0]      exp_count_q[$];
    product_t                    exp_prod_q[$];
    logic                        exp_mac_q[$];
    int                          done_count = 0;
    int                          expected_dones = 0;
    int                          error_count = 0;
    int                          check_count = 0;
    int                          test_count = 0;
    integer                      seed;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_clock (.clk(clk));

    approx_mac_top #(
        .ACC_WIDTH   (ACC_WIDTH),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .x          (x),
        .y          (y),
        .done       (done),
        .acc_value  (acc_value),
        .err_total  (err_total),
        .term_count (term_count)
    );

    function automatic logic pp_bit(operand_t a, operand_t b, int row, int col);
        logic bit_val;
        bit_val = a[row] & b[col];
        // Sign row and sign column are inverted, except where they cross.
        if ((row == OPERAND_WIDTH - 1) != (col == OPERAND_WIDTH - 1)) begin
            bit_val = ~bit_val;
        end
        return bit_val;
    endfunction

    function automatic product_t weighted(logic bit_val, int pos);
        return product_t'(bit_val) << pos;
    endfunction

    function automatic product_t approx_model(operand_t a, operand_t b);
        product_t sum;
        sum = product_t'(1) << (PRODUCT_WIDTH - 1); // Baugh-Wooley constant.
        for (int r = APPROX_LOW_ROWS; r < OPERAND_WIDTH; r++) begin
            for (int c = 0; c < OPERAND_WIDTH; c++) begin
                sum = sum + weighted(pp_bit(a, b, r, c), r + c);
            end
        end
        // Low rows, column by column.
        sum = sum + weighted(pp_bit(a, b, 2, 1) ^ pp_bit(a, b, 3, 0), 3);
        sum = sum + weighted(pp_bit(a, b, 2, 2) ^ pp_bit(a, b, 3, 1), 4);
        sum = sum + weighted(pp_bit(a, b, 4, 0), 4);
        sum = sum + weighted(pp_bit(a, b, 0, 5) ^ pp_bit(a, b, 1, 4), 5);
        sum = sum + weighted(pp_bit(a, b, 2, 3) & pp_bit(a, b, 3, 2), 6);
        sum = sum + weighted(pp_bit(a, b, 4, 2) & pp_bit(a, b, 5, 1), 7);
        sum = sum + weighted(pp_bit(a, b, 4, 3) ^ pp_bit(a, b, 5, 2), 7);
        sum = sum + weighted(pp_bit(a, b, 0, 8) ^ pp_bit(a, b, 1, 7), 8);
        sum = sum + weighted(pp_bit(a, b, 4, 4) ^ pp_bit(a, b, 5, 3), 8);
        sum = sum + weighted(pp_bit(a, b, 0, 9) ^ pp_bit(a, b, 1, 8), 9);
        sum = sum + weighted(pp_bit(a, b, 4, 4) & pp_bit(a, b, 5, 3), 9);
        sum = sum + weighted(pp_bit(a, b, 4, 5) ^ pp_bit(a, b, 5, 4), 9);
        sum = sum + weighted(pp_bit(a, b, 0, 11) ^ pp_bit(a, b, 1, 10), 11);
        sum = sum + weighted(pp_bit(a, b, 0, 12) & pp_bit(a, b, 1, 11), 13);
        sum = sum + weighted(pp_bit(a, b, 0, 14) & pp_bit(a, b, 1, 13), 15);
        sum = sum + weighted(pp_bit(a, b, 1, 15), 17);
        sum = sum + weighted(pp_bit(a, b, 2, 15) ^ pp_bit(a, b, 3, 14), 17);
        sum = sum + weighted(pp_bit(a, b, 4, 12) & pp_bit(a, b, 5, 11), 17);
        sum = sum + weighted(pp_bit(a, b, 4, 13) ^ pp_bit(a, b, 5, 12), 17);
        sum = sum + weighted(pp_bit(a, b, 2, 15) & pp_bit(a, b, 3, 14), 18);
        sum = sum + weighted(pp_bit(a, b, 3, 15), 18);
        sum = sum + weighted(pp_bit(a, b, 4, 13) & pp_bit(a, b, 5, 12), 18);
        sum = sum + weighted(pp_bit(a, b, 4, 13) | pp_bit(a, b, 5, 12), 18);
        sum = sum + weighted(pp_bit(a, b, 4, 14) ^ pp_bit(a, b, 5, 13), 18);
        sum = sum + weighted(pp_bit(a, b, 4, 14) & pp_bit(a, b, 5, 13), 19);
        sum = sum + weighted(pp_bit(a, b, 4, 15) ^ pp_bit(a, b, 5, 14), 19);
        sum = sum + weighted(pp_bit(a, b, 4, 15) & pp_bit(a, b, 5, 14), 20);
        sum = sum + weighted(pp_bit(a, b, 5, 15), 20);
        return sum;
    endfunction

    function automatic product_t exact_model(operand_t a, operand_t b);
        longint wide;
        wide = longint'(a) * longint'(b);
        return product_t'(wide);
    endfunction

    task automatic compare_product(string name, product_t got, product_t expected);
        check_count++;
        if (got !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_acc(string name, logic [ACC_WIDTH-1:0] got,
                               logic [ACC_WIDTH-1:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_count(string name, logic [COUNT_WIDTH-1:0] got,
                                 logic [COUNT_WIDTH-1:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic model_apply(mac_opcode_e op, operand_t a, operand_t b);
        product_t approx_p;
        product_t exact_p;
        product_t chosen;
        longint   diff;
        approx_p = approx_model(a, b);
        exact_p  = exact_model(a, b);
        chosen   = exact_p;
        if (op == OP_CLEAR) begin
            model_acc   = '0;
            model_err   = '0;
            model_count = '0;
        end else if (op == OP_MAC_APPROX) begin
            chosen = approx_p;
            diff   = longint'(exact_p) - longint'(approx_p);
            if (diff < 0) begin
                diff = -diff;
            end
            model_err = model_err + ACC_WIDTH'(diff);
        end
        if (op == OP_MAC_APPROX || op == OP_MAC_EXACT) begin
            model_acc   = model_acc + longint'(chosen); // Wraps at ACC_WIDTH.
            model_count = model_count + 1'b1;
        end
        if (op != OP_NOP) begin
            exp_acc_q.push_back(model_acc);
            exp_err_q.push_back(model_err);
            exp_count_q.push_back(model_count);
            exp_prod_q.push_back(chosen);
            exp_mac_q.push_back(op != OP_CLEAR);
            expected_dones++;
        end
    endtask

    task automatic drive_cmd(mac_opcode_e op, operand_t a, operand_t b);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        x         <= a;
        y         <= b;
        model_apply(op, a, b);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd_op    <= OP_NOP;
    endtask

    // The count moves at the falling edge, so it is seen one edge after the pulse.
    task automatic wait_for_done(output int cycles);
        cycles = 0;
        while (done_count < expected_dones && cycles < DONE_TIMEOUT) begin
            drive_idle();
            cycles++;
        end
        if (done_count < expected_dones) begin
            $display("Timed out waiting for done, %0d of %0d pulses seen",
                     done_count, expected_dones);
            error_count++;
        end
    endtask

    task automatic check_totals();
        @(negedge clk);
        compare_acc("acc_value", acc_value, model_acc);
        compare_acc("err_total", err_total, model_err);
        compare_count("term_count", term_count, model_count);
    endtask

    task automatic report_test(string name, int errors_before);
        test_count++;
        $display("%s: %0d errors", name, error_count - errors_before);
    endtask

    // Each done retires the oldest command in flight.
    always @(negedge clk) begin : done_monitor
        product_t step;
        if (done) begin
            done_count++;
            if (exp_acc_q.size() == 0) begin
                $display("done pulsed with no command in flight");
                error_count++;
            end else begin
                step = product_t'(acc_value - last_acc);
                if (exp_mac_q.pop_front()) begin
                    compare_product("acc_value step", step, exp_prod_q.pop_front());
                end else begin
                    void'(exp_prod_q.pop_front());
                end
                compare_acc("acc_value", acc_value, exp_acc_q.pop_front());
                compare_acc("err_total", err_total, exp_err_q.pop_front());
                compare_count("term_count", term_count, exp_count_q.pop_front());
                last_acc = acc_value;
            end
        end
    end

    task automatic test_reset_values();
        int errors_before;
        errors_before = error_count;
        repeat (4) begin
            drive_idle();
        end
        @(negedge clk);
        if (done_count != 0) begin
            $display("done pulsed after reset with cmd_valid low");
            error_count++;
        end
        compare_acc("acc_value", acc_value, '0);
        compare_acc("err_total", err_total, '0);
        compare_count("term_count", term_count, '0);
        report_test("reset_values", errors_before);
    endtask

    task automatic test_single(string name, mac_opcode_e op);
        int       errors_before;
        int       cycles;
        operand_t a;
        operand_t b;
        errors_before = error_count;
        a = operand_t'($random(seed));
        b = operand_t'($random(seed));
        drive_cmd(op, a, b);
        wait_for_done(cycles);
        if (cycles != LATENCY + 1) begin
            $display("done arrived %0d cycles after the command, expected %0d",
                     cycles - 1, LATENCY);
            error_count++;
        end
        check_totals();
        report_test(name, errors_before);
    endtask

    task automatic test_random_mix();
        int          errors_before;
        int          dones_before;
        int          issued_before;
        int          cycles;
        logic [31:0] rnd;
        operand_t    a;
        operand_t    b;
        errors_before = error_count;
        dones_before  = done_count;
        issued_before = expected_dones;
        repeat (40) begin
            rnd = $random(seed);
            a   = operand_t'($random(seed));
            b   = operand_t'($random(seed));
            drive_cmd(mac_opcode_e'(rnd[1:0]), a, b);
        end
        wait_for_done(cycles);
        check_totals();
        if (done_count - dones_before != expected_dones - issued_before) begin
            $display("Saw %0d done pulses for %0d commands",
                     done_count - dones_before, expected_dones - issued_before);
            error_count++;
        end
        report_test("random_mix", errors_before);
    endtask

    task automatic test_clear_between();
        int          errors_before;
        int          cycles;
        mac_opcode_e ops[5];
        operand_t    a;
        operand_t    b;
        errors_before = error_count;
        ops = '{OP_MAC_APPROX, OP_MAC_EXACT, OP_CLEAR, OP_MAC_EXACT, OP_MAC_APPROX};
        foreach (ops[i]) begin
            a = operand_t'($random(seed));
            b = operand_t'($random(seed));
            drive_cmd(ops[i], a, b);
        end
        wait_for_done(cycles);
        check_totals();
        compare_count("term_count", term_count, 2); // Only MACs after the clear.
        report_test("clear_between", errors_before);
    endtask

    task automatic test_corners();
        int       errors_before;
        int       cycles;
        operand_t corner_x[4];
        operand_t corner_y[4];
        errors_before = error_count;
        corner_x = '{16'sh8000, 16'sh0000, 16'shffff, 16'shffff};
        corner_y = '{16'sh8000, 16'sh7fff, 16'shffff, 16'sh8000};
        foreach (corner_x[i]) begin
            drive_cmd(OP_MAC_EXACT, corner_x[i], corner_y[i]);
            drive_cmd(OP_MAC_APPROX, corner_x[i], corner_y[i]);
        end
        wait_for_done(cycles);
        check_totals();
        report_test("corners", errors_before);
    endtask

    initial begin
        seed        = 32'h72d0;
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd_op      = OP_NOP;
        x           = '0;
        y           = '0;
        model_acc   = '0;
        model_err   = '0;
        model_count = '0;
        last_acc    = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        test_reset_values();
        test_single("single_exact", OP_MAC_EXACT);
        test_single("single_approx", OP_MAC_APPROX);
        test_random_mix();
        test_clear_between();
        test_corners();
        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verification/approx_mac_properties.sv
`timescale 1ns/100ps

module approx_mac_properties import mac_ctrl_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        cmd_valid,
    input mac_opcode_e cmd_op,
    input logic        done,
    input logic        acc_enable,
    input logic        clear_all,
    input logic        s1_valid,
    input logic        s2_valid,
    input ctrl_state_e state
);

    // Two-cycle latency from the drive edge.
    done_has_command: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(cmd_valid && cmd_op != OP_NOP, 2))
        else $error("done without a command two cycles earlier");

    enable_clear_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(acc_enable && clear_all))
        else $error("acc_enable and clear_all high together");

    idle_when_empty: assert property (@(posedge clk) disable iff (reset)
        (!s1_valid && !s2_valid) |-> state == IDLE)
        else $error("controller not IDLE with an empty pipeline");

endmodule

bind approx_mac_top approx_mac_properties i_props (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .done       (done),
    .acc_enable (acc_enable),
    .clear_all  (clear_all),
    .s1_valid   (i_control.s1_valid),
    .s2_valid   (i_control.s2_valid),
    .state      (i_control.state)
);

// File: verification/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: hdl/approx_mac_top.sv
`timescale 1ns/100ps

module approx_mac_top import mac_arith_pkg::*, mac_ctrl_pkg::*; #(
    parameter int ACC_WIDTH   = 40,
    parameter int COUNT_WIDTH = 16
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cmd_valid,
    input  mac_opcode_e                 cmd_op,
    input  operand_t                    x,
    input  operand_t                    y,
    output logic                        done,
    output logic signed [ACC_WIDTH-1:0] acc_value,
    output logic [ACC_WIDTH-1:0]        err_total,
    output logic [COUNT_WIDTH-1:0]      term_count
);

    logic     load;
    logic     acc_enable;
    logic     err_enable;
    logic     use_exact;
    logic     clear_all;
    product_t approx_product;
    product_t exact_product;

    mac_control i_control (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .load       (load),
        .acc_enable (acc_enable),
        .err_enable (err_enable),
        .use_exact  (use_exact),
        .clear_all  (clear_all),
        .done       (done)
    );

    product_stage i_product (
        .clk            (clk),
        .reset          (reset),
        .load           (load),
        .x              (x),
        .y              (y),
        .approx_product (approx_product),
        .exact_product  (exact_product)
    );

    accumulator #(
        .ACC_WIDTH   (ACC_WIDTH),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_acc (
        .clk            (clk),
        .reset          (reset),
        .enable         (acc_enable),
        .clear          (clear_all),
        .use_exact      (use_exact),
        .approx_product (approx_product),
        .exact_product  (exact_product),
        .acc_value      (acc_value),
        .term_count     (term_count)
    );

    error_tracker #(
        .ACC_WIDTH (ACC_WIDTH)
    ) i_err (
        .clk            (clk),
        .reset          (reset),
        .enable         (err_enable),
        .clear          (clear_all),
        .approx_product (approx_product),
        .exact_product  (exact_product),
        .err_total      (err_total)
    );

endmodule

// File: hdl/mac_control.sv
`timescale 1ns/100ps

module mac_control import mac_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_valid,
    input  mac_opcode_e cmd_op,
    output logic        load,
    output logic        acc_enable,
    output logic        err_enable,
    output logic        use_exact,
    output logic        clear_all,
    output logic        done
);

    logic        s1_valid;
    mac_opcode_e s1_op;
    logic        s2_valid;
    mac_opcode_e s2_op;
    ctrl_state_e state;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s1_op    <= OP_NOP;
            s2_op    <= OP_NOP;
            state    <= IDLE;
        end else begin
            s1_valid <= cmd_valid;
            s1_op    <= cmd_op;
            s2_valid <= s1_valid;
            s2_op    <= s1_op;
            state    <= (cmd_valid || s1_valid) ? BUSY : IDLE; // Tracks next valids.
        end
    end

    // Products are captured for MAC commands only.
    assign load = cmd_valid && (cmd_op == OP_MAC_APPROX || cmd_op == OP_MAC_EXACT);

    // Stage-1 enables.
    assign acc_enable = s1_valid && (s1_op == OP_MAC_APPROX || s1_op == OP_MAC_EXACT);
    assign err_enable = s1_valid && (s1_op == OP_MAC_APPROX);
    assign use_exact  = (s1_op == OP_MAC_EXACT);
    assign clear_all  = s1_valid && (s1_op == OP_CLEAR);

    assign done = s2_valid && (s2_op != OP_NOP); // Totals are final here.

endmodule

// File: hdl/error_tracker.sv
`timescale 1ns/100ps

module error_tracker import mac_arith_pkg::*; #(
    parameter int ACC_WIDTH = 40
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  logic                 clear,
    input  product_t             approx_product,
    input  product_t             exact_product,
    output logic [ACC_WIDTH-1:0] err_total
);

    // One extra bit so the difference cannot overflow.
    logic signed [PRODUCT_WIDTH:0] diff;
    logic [PRODUCT_WIDTH:0]        magnitude;

    assign diff = {exact_product[PRODUCT_WIDTH-1], exact_product}
                - {approx_product[PRODUCT_WIDTH-1], approx_product};

    assign magnitude = diff[PRODUCT_WIDTH] ? -diff : diff;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            err_total <= '0;
        end else if (enable) begin
            err_total <= err_total + {{(ACC_WIDTH-PRODUCT_WIDTH-1){1'b0}}, magnitude};
        end
    end

endmodule

// File: hdl/accumulator.sv
`timescale 1ns/100ps

module accumulator import mac_arith_pkg::*; #(
    parameter int ACC_WIDTH   = 40,
    parameter int COUNT_WIDTH = 16
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        enable,
    input  logic                        clear,
    input  logic                        use_exact,
    input  product_t                    approx_product,
    input  product_t                    exact_product,
    output logic signed [ACC_WIDTH-1:0] acc_value,
    output logic [COUNT_WIDTH-1:0]      term_count
);

    product_t                    selected;
    logic signed [ACC_WIDTH-1:0] addend;

    assign selected = use_exact ? exact_product : approx_product;

    // Sign extension to the accumulator width.
    assign addend = {{(ACC_WIDTH-PRODUCT_WIDTH){selected[PRODUCT_WIDTH-1]}}, selected};

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            acc_value  <= '0;
            term_count <= '0;
        end else if (enable) begin
            acc_value  <= acc_value + addend; // Wraps on overflow.
            term_count <= term_count + 1'b1;
        end
    end

endmodule

// File: hdl/product_stage.sv
`timescale 1ns/100ps

module product_stage import mac_arith_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  operand_t x,
    input  operand_t y,
    output product_t approx_product,
    output product_t exact_product
);

    product_t approx_z;
    product_t exact_z;

    approx_multiplier i_mult (
        .x (x),
        .y (y),
        .z (approx_z)
    );

    // Sign-extend before multiplying to keep the full 32-bit result.
    assign exact_z = product_t'(x) * product_t'(y);

    // Both products of one command stay aligned.
    always_ff @(posedge clk) begin
        if (reset) begin
            approx_product <= '0;
            exact_product  <= '0;
        end else if (load) begin
            approx_product <= approx_z;
            exact_product  <= exact_z;
        end
    end

endmodule

// File: approx_multiplier/approx_multiplier.sv
`timescale 1ns/100ps

module approx_multiplier import mac_arith_pkg::*; (
    input  operand_t x,
    input  operand_t y,
    output product_t z
);

    pp_row_t    pp [OPERAND_WIDTH];
    comp_word_t comp1;
    comp_word_t comp2;
    comp_word_t comp3;
    comp_word_t comp4;
    comp_word_t comp5;
    product_t   row_sum;

    // Baugh-Wooley rows with inverted sign terms.
    always_comb begin
        for (int i = 0; i < OPERAND_WIDTH - 1; i++) begin
            pp[i][OPERAND_WIDTH-2:0] = y[OPERAND_WIDTH-2:0] & {(OPERAND_WIDTH-1){x[i]}};
            pp[i][OPERAND_WIDTH-1]   = ~(y[OPERAND_WIDTH-1] & x[i]);
        end
        pp[OPERAND_WIDTH-1][OPERAND_WIDTH-2:0] =
            ~(y[OPERAND_WIDTH-2:0] & {(OPERAND_WIDTH-1){x[OPERAND_WIDTH-1]}});
        pp[OPERAND_WIDTH-1][OPERAND_WIDTH-1] = y[OPERAND_WIDTH-1] & x[OPERAND_WIDTH-1];
    end

    // Incomplete compression of rows 0 to 5.
    // Bits that no term picks up are dropped on purpose.
    always_comb begin
        comp1     = '0;
        comp1[3]  = pp[2][1] ^ pp[3][0];
        comp1[4]  = pp[2][2] ^ pp[3][1];
        comp1[5]  = pp[0][5] ^ pp[1][4];
        comp1[6]  = pp[2][3] & pp[3][2];
        comp1[7]  = pp[4][2] & pp[5][1];
        comp1[8]  = pp[0][8] ^ pp[1][7];
        comp1[9]  = pp[0][9] ^ pp[1][8];
        comp1[11] = pp[0][11] ^ pp[1][10];
        comp1[13] = pp[0][12] & pp[1][11];
        comp1[15] = pp[0][14] & pp[1][13];
        comp1[17] = pp[1][15];
        comp1[18] = pp[2][15] & pp[3][14];
        comp1[19] = pp[4][14] & pp[5][13];
        comp1[20] = pp[4][15] & pp[5][14];
    end

    always_comb begin
        comp2     = '0;
        comp2[4]  = pp[4][0];
        comp2[7]  = pp[4][3] ^ pp[5][2];
        comp2[8]  = pp[4][4] ^ pp[5][3];
        comp2[9]  = pp[4][4] & pp[5][3];
        comp2[17] = pp[2][15] ^ pp[3][14];
        comp2[18] = pp[3][15];
        comp2[19] = pp[4][15] ^ pp[5][14];
        comp2[20] = pp[5][15];
    end

    always_comb begin
        comp3     = '0;
        comp3[9]  = pp[4][5] ^ pp[5][4];
        comp3[17] = pp[4][12] & pp[5][11];
        comp3[18] = pp[4][13] & pp[5][12];
    end

    always_comb begin
        comp4     = '0;
        comp4[17] = pp[4][13] ^ pp[5][12];
        comp4[18] = pp[4][13] | pp[5][12]; // OR stands in for the carry.
    end

    always_comb begin
        comp5     = '0;
        comp5[18] = pp[4][14] ^ pp[5][13];
    end

    // Exact rows 6 to 15, shifted into place.
    always_comb begin
        row_sum = BW_TOP_ONE;
        for (int i = APPROX_LOW_ROWS; i < OPERAND_WIDTH; i++) begin
            row_sum = row_sum + ({{(PRODUCT_WIDTH-OPERAND_WIDTH){1'b0}}, pp[i]} << i);
        end
    end

    // Final multi-operand sum, modulo 2^32.
    assign z = row_sum
             + {{(PRODUCT_WIDTH-COMP_WIDTH){1'b0}}, comp1}
             + {{(PRODUCT_WIDTH-COMP_WIDTH){1'b0}}, comp2}
             + {{(PRODUCT_WIDTH-COMP_WIDTH){1'b0}}, comp3}
             + {{(PRODUCT_WIDTH-COMP_WIDTH){1'b0}}, comp4}
             + {{(PRODUCT_WIDTH-COMP_WIDTH){1'b0}}, comp5};

endmodule

// File: common/mac_ctrl_pkg.sv
package mac_ctrl_pkg;

    // Command opcodes.
    typedef enum logic [1:0] {
        OP_NOP        = 2'b00,
        OP_CLEAR      = 2'b01, // Zero all totals.
        OP_MAC_APPROX = 2'b10,
        OP_MAC_EXACT  = 2'b11
    } mac_opcode_e;

    // Controller state.
    typedef enum logic {
        IDLE = 1'b0, // Pipeline empty.
        BUSY = 1'b1  // Command in flight.
    } ctrl_state_e;

endpackage

// File: common/mac_arith_pkg.sv
package mac_arith_pkg;

    // The approximation pattern is defined for 16-bit operands only.
    localparam int OPERAND_WIDTH = 16;
    localparam int PRODUCT_WIDTH = 32;

    // Rows below this index feed the compressor instead of the final sum.
    localparam int APPROX_LOW_ROWS = 6;

    // Width of each compressed correction word.
    localparam int COMP_WIDTH = 21;

    typedef logic signed [OPERAND_WIDTH-1:0] operand_t;
    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

    // One Baugh-Wooley partial-product row, before shifting.
    typedef logic [OPERAND_WIDTH-1:0] pp_row_t;

    typedef logic [COMP_WIDTH-1:0] comp_word_t;

    // Constant one of the top Baugh-Wooley row, at bit 31.
    localparam product_t BW_TOP_ONE = product_t'(1) <<< (PRODUCT_WIDTH - 1);

endpackage
